/* ffnn_approx.f */
+incdir+logic
logic/ffnn_pkg.sv
logic/hidden_layer.sv
logic/score_layer.sv
logic/class_select.sv
logic/ffnn_approx.sv
tb/tb_clock_gen.sv
tb/ffnn_approx_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ffnn_approx_tb
FILELIST  ?= ffnn_approx.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* tb/ffnn_cases.txt */
# Columns: feature a, feature b, feature c, feature d, expected class label.
# All values in hex, sign-magnitude words with bit 15 as the sign.
0000 0000 0000 0000 0
8000 8000 8000 8000 0
8000 0000 8000 0000 0
0100 0000 0000 0000 0
0000 0100 0000 0000 0
0000 0000 0100 0000 2
0000 0000 0000 0100 2
8100 0000 0000 0000 0
0000 8100 0000 0000 0
8000 0000 0100 8000 2
0000 0100 0000 8000 0
8000 8000 0000 0100 2

/* tb/ffnn_approx_tb.sv */
`include "ffnn_defs.svh"
`include "ffnn_weights_defs.svh"

module ffnn_approx_tb;

  import ffnn_pkg::*;

  localparam int TIMEOUT_CYCLES = 20000;
  localparam int RESET_WAIT_MAX = 50;
  localparam int N_RANDOM       = 200;

  localparam logic [32*`FFNN_WORD_W-1:0] W1_TBL = `FFNN_W1;
  localparam logic [8*`FFNN_WORD_W-1:0]  B1_TBL = `FFNN_B1;
  localparam logic [48*`FFNN_WORD_W-1:0] W2_TBL = `FFNN_W2;
  localparam logic [6*`FFNN_WORD_W-1:0]  B2_TBL = `FFNN_B2;
  localparam logic [18*`FFNN_WORD_W-1:0] W3_TBL = `FFNN_W3;
  localparam logic [3*`FFNN_WORD_W-1:0]  B3_TBL = `FFNN_B3;

  logic         clk;
  logic         gen_arst_n;
  logic         sw_rst_n;
  logic         arst_n;
  sm_word_u     a;
  sm_word_u     b;
  sm_word_u     c;
  sm_word_u     d;
  class_label_t result;

  feature_vec_t case_feat[$];
  class_label_t case_lab[$];
  class_label_t exp_pipe[4];
  bit           vld_pipe[4];
  logic [31:0]  rng_state;
  int           errors;
  int           checks;

  tb_clock_gen #(.PERIOD(20), .RST_CYCLES(2)) u_clk (
    .clk    (clk),
    .arst_n (gen_arst_n)
  );

  // Generator reset plus a second source for the mid-stream reset test.
  assign arst_n = gen_arst_n & sw_rst_n;

  ffnn_approx dut (
    .clk    (clk),
    .arst_n (arst_n),
    .a      (a),
    .b      (b),
    .c      (c),
    .d      (d),
    .result (result)
  );

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic acc_t sm_value(sm_word_u w);
    if (w.f.sign) begin
      return -acc_t'(w.f.mag);
    end
    return acc_t'(w.f.mag);
  endfunction

  // ReLU with shift and clamp.
  function automatic sm_word_u relu_act(acc_t acc);
    sm_word_u r;
    acc_t     s;
    r.raw = '0;
    if (acc > 0) begin
      s = acc >>> `FFNN_ACT_SHIFT;
      if (s > acc_t'(`FFNN_ACT_MAX)) begin
        r.f.mag = '1;
      end else begin
        r.f.mag = s[`FFNN_WORD_W-2:0];
      end
    end
    return r;
  endfunction

  function automatic class_label_t predict_label(feature_vec_t f);
    sm_word_u     h1 [`FFNN_N_H1];
    sm_word_u     h2 [`FFNN_N_H2];
    acc_t         sc [`FFNN_N_CLASS];
    acc_t         acc;
    sm_word_u     w;
    class_label_t best;
    for (int j = 0; j < `FFNN_N_H1; j++) begin
      w.raw = B1_TBL[j*`FFNN_WORD_W +: `FFNN_WORD_W];
      acc   = sm_value(w);
      for (int i = 0; i < `FFNN_N_IN; i++) begin
        w.raw = W1_TBL[(j*`FFNN_N_IN+i)*`FFNN_WORD_W +: `FFNN_WORD_W];
        acc   = acc + sm_product(f[i], w);
      end
      h1[j] = relu_act(acc);
    end
    for (int j = 0; j < `FFNN_N_H2; j++) begin
      w.raw = B2_TBL[j*`FFNN_WORD_W +: `FFNN_WORD_W];
      acc   = sm_value(w);
      for (int i = 0; i < `FFNN_N_H1; i++) begin
        w.raw = W2_TBL[(j*`FFNN_N_H1+i)*`FFNN_WORD_W +: `FFNN_WORD_W];
        acc   = acc + sm_product(h1[i], w);
      end
      h2[j] = relu_act(acc);
    end
    for (int k = 0; k < `FFNN_N_CLASS; k++) begin
      w.raw = B3_TBL[k*`FFNN_WORD_W +: `FFNN_WORD_W];
      acc   = sm_value(w);
      for (int i = 0; i < `FFNN_N_H2; i++) begin
        w.raw = W3_TBL[(k*`FFNN_N_H2+i)*`FFNN_WORD_W +: `FFNN_WORD_W];
        acc   = acc + sm_product(h2[i], w);
      end
      sc[k] = acc;
    end
    // Ties keep the lower index.
    best = '0;
    for (int k = 1; k < `FFNN_N_CLASS; k++) begin
      if (sc[k] > sc[best]) begin
        best = class_label_t'(k);
      end
    end
    return best;
  endfunction

  function automatic feature_vec_t make_vec(logic [15:0] fa, logic [15:0] fb,
                                            logic [15:0] fc, logic [15:0] fd);
    feature_vec_t v;
    v[0].raw = fa;
    v[1].raw = fb;
    v[2].raw = fc;
    v[3].raw = fd;
    return v;
  endfunction

  task automatic next_features(output feature_vec_t f);
    for (int i = 0; i < `FFNN_N_IN; i++) begin
      rng_state = lcg_next(rng_state);
      f[i].raw  = rng_state[31:16];
      // Some words kept small so the ReLU does not always saturate.
      if (rng_state[3]) begin
        f[i].raw = {rng_state[31], 5'b0, rng_state[25:16]};
      end
    end
  endtask

  task automatic check_label(string tag, class_label_t got, class_label_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: result got %h expected %h", tag, got, exp);
    end
  endtask

  // One cycle. Drive at the rising edge, check the vector from four edges back.
  task automatic drive_cycle(bit valid, feature_vec_t f, class_label_t exp);
    @(posedge clk);
    a <= f[0];
    b <= f[1];
    c <= f[2];
    d <= f[3];
    @(negedge clk);
    if (vld_pipe[3]) begin
      check_label("result", result, exp_pipe[3]);
    end
    for (int k = 3; k > 0; k--) begin
      vld_pipe[k] = vld_pipe[k-1];
      exp_pipe[k] = exp_pipe[k-1];
    end
    vld_pipe[0] = valid;
    exp_pipe[0] = exp;
  endtask

  task automatic flush_pipe();
    for (int k = 0; k < 4; k++) begin
      drive_cycle(1'b0, '0, '0);
    end
  endtask

  task automatic report_test(string name, int err_before);
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err_before);
    end
  endtask

  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    logic [15:0] v0;
    logic [15:0] v1;
    logic [15:0] v2;
    logic [15:0] v3;
    logic [7:0]  lab;
    fd = $fopen("tb/ffnn_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the case file tb/ffnn_cases.txt");
      return;
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) begin
        break;
      end
      if (line.len() > 0 && line[0] != 8'h23) begin
        n = $sscanf(line, "%h %h %h %h %h", v0, v1, v2, v3, lab);
        if (n == 5) begin
          case_feat.push_back(make_vec(v0, v1, v2, v3));
          case_lab.push_back(class_label_t'(lab));
        end
      end
    end
    $fclose(fd);
    if (case_feat.size() == 0) begin
      errors++;
      $display("the case file held no usable cases");
    end
  endtask

  initial begin
    #(TIMEOUT_CYCLES * 20);
    $display("simulation ran past %0d cycles without finishing", TIMEOUT_CYCLES);
    $display("Test failures found");
    $finish;
  end

  initial begin
    feature_vec_t f;
    feature_vec_t extremes[$];
    int           n;
    int           err0;
    a         = '0;
    b         = '0;
    c         = '0;
    d         = '0;
    sw_rst_n  = 1'b1;
    errors    = 0;
    checks    = 0;
    rng_state = 32'h62a2_f961;
    for (int k = 0; k < 4; k++) begin
      vld_pipe[k] = 1'b0;
      exp_pipe[k] = '0;
    end
    load_cases();

    n = 0;
    while (!gen_arst_n && n < RESET_WAIT_MAX) begin
      @(posedge clk);
      n++;
    end
    if (!gen_arst_n) begin
      errors++;
      $display("reset was never released by the clock generator");
    end

    err0 = errors;
    @(negedge clk);
    check_label("after reset", result, '0);
    report_test("reset_value", err0);

    err0 = errors;
    foreach (case_feat[i]) begin
      drive_cycle(1'b1, case_feat[i], case_lab[i]);
      flush_pipe();
    end
    report_test("directed_cases", err0);

    err0 = errors;
    foreach (case_feat[i]) begin
      drive_cycle(1'b1, case_feat[i], case_lab[i]);
    end
    flush_pipe();
    report_test("back_to_back", err0);

    err0 = errors;
    extremes.push_back(make_vec(16'h7fff, 16'h7fff, 16'h7fff, 16'h7fff));
    extremes.push_back(make_vec(16'hffff, 16'hffff, 16'hffff, 16'hffff));
    extremes.push_back(make_vec(16'h7fff, 16'hffff, 16'h7fff, 16'hffff));
    extremes.push_back(make_vec(16'hffff, 16'h7fff, 16'hffff, 16'h7fff));
    extremes.push_back(make_vec(16'h8123, 16'h8456, 16'h8789, 16'h8abc));
    extremes.push_back(make_vec(16'h7fff, 16'h0000, 16'h0000, 16'h0000));
    extremes.push_back(make_vec(16'h0000, 16'h0000, 16'h7fff, 16'h0000));
    extremes.push_back(make_vec(16'h0000, 16'h0000, 16'h0000, 16'h7fff));
    foreach (extremes[i]) begin
      drive_cycle(1'b1, extremes[i], predict_label(extremes[i]));
    end
    flush_pipe();
    report_test("saturation", err0);

    err0 = errors;
    for (int i = 0; i < N_RANDOM; i++) begin
      next_features(f);
      drive_cycle(1'b1, f, predict_label(f));
    end
    flush_pipe();
    report_test("random_stream", err0);

    err0 = errors;
    for (int i = 0; i < 6; i++) begin
      if (i == 1) begin
        // Class 2 vector, on result when the reset hits.
        f = make_vec(16'h0000, 16'h0000, 16'h0100, 16'h0000);
      end else begin
        next_features(f);
      end
      drive_cycle(1'b1, f, predict_label(f));
    end
    // Asserted between edges, so only the async path can clear result.
    sw_rst_n = 1'b0;
    #1;
    check_label("during reset", result, '0);
    for (int k = 0; k < 4; k++) begin
      vld_pipe[k] = 1'b0;
    end
    drive_cycle(1'b0, '0, '0);
    drive_cycle(1'b0, '0, '0);
    check_label("held in reset", result, '0);
    sw_rst_n = 1'b1;
    for (int i = 0; i < 20; i++) begin
      next_features(f);
      drive_cycle(1'b1, f, predict_label(f));
    end
    flush_pipe();
    report_test("mid_stream_reset", err0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* tb/tb_clock_gen.sv */
module tb_clock_gen #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 2
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

/* logic/ffnn_approx.sv */
`include "ffnn_defs.svh"
`include "ffnn_weights_defs.svh"

module ffnn_approx (
  input  logic                   clk,
  input  logic                   arst_n,
  input  ffnn_pkg::sm_word_u     a,
  input  ffnn_pkg::sm_word_u     b,
  input  ffnn_pkg::sm_word_u     c,
  input  ffnn_pkg::sm_word_u     d,
  output ffnn_pkg::class_label_t result
);

  import ffnn_pkg::*;

  feature_vec_t  features;
  h1_vec_t       h1_act;
  h2_vec_t       h2_act;
  class_scores_s scores;

  // Feature a is input 0.
  assign features = {d, c, b, a};

  hidden_layer #(
    .N_IN    (`FFNN_N_IN),
    .N_OUT   (`FFNN_N_H1),
    .WEIGHTS (`FFNN_W1),
    .BIASES  (`FFNN_B1)
  ) u_layer1 (
    .clk     (clk),
    .arst_n  (arst_n),
    .act_in  (features),
    .act_out (h1_act)
  );

  hidden_layer #(
    .N_IN    (`FFNN_N_H1),
    .N_OUT   (`FFNN_N_H2),
    .WEIGHTS (`FFNN_W2),
    .BIASES  (`FFNN_B2)
  ) u_layer2 (
    .clk     (clk),
    .arst_n  (arst_n),
    .act_in  (h1_act),
    .act_out (h2_act)
  );

  score_layer #(
    .N_IN    (`FFNN_N_H2),
    .WEIGHTS (`FFNN_W3),
    .BIASES  (`FFNN_B3)
  ) u_scores (
    .clk     (clk),
    .arst_n  (arst_n),
    .act_in  (h2_act),
    .scores  (scores)
  );

  // Last stage, four edges from the features.
  class_select u_select (
    .clk     (clk),
    .arst_n  (arst_n),
    .scores  (scores),
    .label   (result)
  );

endmodule

/* logic/class_select.sv */
`include "ffnn_defs.svh"

module class_select (
  input  logic                    clk,
  input  logic                    arst_n,
  input  ffnn_pkg::class_scores_s scores,
  output ffnn_pkg::class_label_t  label
);

  import ffnn_pkg::*;

  class_label_t pick;

  // Strict compares keep the lower index on a tie.
  always_comb begin
    acc_t best;
    best = scores.score0;
    pick = class_label_t'(0);
    if (scores.score1 > best) begin
      best = scores.score1;
      pick = class_label_t'(1);
    end
    if (scores.score2 > best) begin
      pick = class_label_t'(2);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      label <= '0;
    end else begin
      label <= pick;
    end
  end

  // Encoding 3 is never a class.
  a_label_range: assert property (
    @(posedge clk) disable iff (!arst_n)
    label < class_label_t'(`FFNN_N_CLASS)
  );

endmodule

/* logic/score_layer.sv */
`include "ffnn_defs.svh"

module score_layer #(
  parameter int N_IN = `FFNN_N_H2,
  parameter logic [`FFNN_N_CLASS*N_IN*`FFNN_WORD_W-1:0] WEIGHTS = '0,
  parameter logic [`FFNN_N_CLASS*`FFNN_WORD_W-1:0]      BIASES  = '0
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  ffnn_pkg::h2_vec_t       act_in,
  output ffnn_pkg::class_scores_s scores
);

  import ffnn_pkg::*;

  acc_t [`FFNN_N_CLASS-1:0] sums;

  // Plain dot product plus bias, no activation.
  always_comb begin
    sm_word_u w;
    sm_word_u bias;
    for (int k = 0; k < `FFNN_N_CLASS; k++) begin
      bias.raw = BIASES[k*`FFNN_WORD_W +: `FFNN_WORD_W];
      if (bias.f.sign) begin
        sums[k] = -acc_t'(bias.f.mag);
      end else begin
        sums[k] = acc_t'(bias.f.mag);
      end

      for (int i = 0; i < N_IN; i++) begin
        w.raw   = WEIGHTS[(k*N_IN+i)*`FFNN_WORD_W +: `FFNN_WORD_W];
        sums[k] = sums[k] + sm_product(act_in[i], w);
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      scores <= '0;
    end else begin
      scores <= '{score0: sums[0], score1: sums[1], score2: sums[2]};
    end
  end

  // Known activations give known scores one cycle later.
  a_scores_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    !$isunknown(act_in) |=> !$isunknown(scores)
  );

endmodule

/* logic/hidden_layer.sv */
`include "ffnn_defs.svh"

module hidden_layer #(
  parameter int N_IN  = `FFNN_N_IN,
  parameter int N_OUT = `FFNN_N_H1,
  parameter logic [N_OUT*N_IN*`FFNN_WORD_W-1:0] WEIGHTS = '0,
  parameter logic [N_OUT*`FFNN_WORD_W-1:0]      BIASES  = '0
) (
  input  logic                           clk,
  input  logic                           arst_n,
  input  ffnn_pkg::sm_word_u [N_IN-1:0]  act_in,
  output ffnn_pkg::sm_word_u [N_OUT-1:0] act_out
);

  import ffnn_pkg::*;

  sm_word_u [N_OUT-1:0] act_next;

  always_comb begin
    acc_t     acc;
    acc_t     scaled;
    sm_word_u w;
    sm_word_u bias;
    for (int j = 0; j < N_OUT; j++) begin
      bias.raw = BIASES[j*`FFNN_WORD_W +: `FFNN_WORD_W];
      if (bias.f.sign) begin
        acc = -acc_t'(bias.f.mag);
      end else begin
        acc = acc_t'(bias.f.mag);
      end

      for (int i = 0; i < N_IN; i++) begin
        w.raw = WEIGHTS[(j*N_IN+i)*`FFNN_WORD_W +: `FFNN_WORD_W];
        acc   = acc + sm_product(act_in[i], w);
      end

      // ReLU, then rescale and clamp.
      scaled = acc >>> `FFNN_ACT_SHIFT;
      act_next[j].f.sign = 1'b0;
      if (acc <= 0) begin
        act_next[j].f.mag = '0;
      end else if (scaled > acc_t'(`FFNN_ACT_MAX)) begin
        act_next[j].f.mag = (`FFNN_WORD_W-1)'(`FFNN_ACT_MAX);
      end else begin
        act_next[j].f.mag = scaled[`FFNN_WORD_W-2:0];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      act_out <= '0;
    end else begin
      act_out <= act_next;
    end
  end

  // Downstream layers treat activations as non-negative.
  for (genvar j = 0; j < N_OUT; j++) begin : g_sign_chk
    a_act_sign_clear: assert property (
      @(posedge clk) disable iff (!arst_n)
      !act_out[j].f.sign
    );
  end

  // Once out of reset and fed known features, the stage never goes X.
  a_act_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    !$isunknown(act_in) |=> !$isunknown(act_out)
  );

endmodule

/* logic/ffnn_pkg.sv */
`include "ffnn_defs.svh"

package ffnn_pkg;

  // Sign bit on top, magnitude below.
  typedef struct packed {
    logic                     sign;
    logic [`FFNN_WORD_W-2:0]  mag;
  } sm_fields_s;

  // One word, seen either as raw bits or as its fields.
  typedef union packed {
    logic [`FFNN_WORD_W-1:0]  raw;
    sm_fields_s               f;
  } sm_word_u;

  typedef logic signed [`FFNN_ACC_W-1:0] acc_t;

  typedef sm_word_u [`FFNN_N_IN-1:0] feature_vec_t;
  typedef sm_word_u [`FFNN_N_H1-1:0] h1_vec_t;
  typedef sm_word_u [`FFNN_N_H2-1:0] h2_vec_t;

  // Raw output-layer sums, one per class.
  typedef struct packed {
    acc_t score0;
    acc_t score1;
    acc_t score2;
  } class_scores_s;

  typedef logic [$clog2(`FFNN_N_CLASS)-1:0] class_label_t;

  // Magnitudes multiply, signs combine by XOR.
  // A negative zero operand still gives zero.
  function automatic acc_t sm_product(sm_word_u x, sm_word_u y);
    acc_t mag;
    mag = acc_t'(x.f.mag) * acc_t'(y.f.mag);
    if (x.f.sign ^ y.f.sign) begin
      return -mag;
    end
    return mag;
  endfunction

endpackage

/* logic/ffnn_defs.svh */
`ifndef FFNN_DEFS_SVH
`define FFNN_DEFS_SVH

// Layer sizes.
`define FFNN_N_IN       4
`define FFNN_N_H1       8
`define FFNN_N_H2       6
`define FFNN_N_CLASS    3

// Bit 15 of each word carries the sign.
`define FFNN_WORD_W     16

// Two's-complement accumulator for dot products.
`define FFNN_ACC_W      32

// Positive hidden sums are scaled down by this shift.
`define FFNN_ACT_SHIFT  4

// Largest magnitude an activation can hold.
`define FFNN_ACT_MAX    32767

`endif

/* logic/ffnn_weights_defs.svh */
`ifndef FFNN_WEIGHTS_DEFS_SVH
`define FFNN_WEIGHTS_DEFS_SVH

// Sign-magnitude constants. Entry j*N_IN+i sits at bits [16*(j*N_IN+i) +: 16].
// Each row below is one neuron, listed from the last neuron down to neuron 0,
// and within a row from the last input down to input 0.

// Layer 1, 4 inputs by 8 neurons.
`define FFNN_W1 { \
  16'h8023, 16'h8029, 16'h0027, 16'h001D, \
  16'h002C, 16'h0013, 16'h0001, 16'h000D, \
  16'h0018, 16'h8018, 16'h8005, 16'h8017, \
  16'h001A, 16'h8010, 16'h801B, 16'h801A, \
  16'h0018, 16'h0023, 16'h8009, 16'h0025, \
  16'h8003, 16'h8017, 16'h8019, 16'h8026, \
  16'h801D, 16'h801B, 16'h0005, 16'h8025, \
  16'h8021, 16'h8014, 16'h0011, 16'h001E  \
}

`define FFNN_B1 { \
  16'h0007, 16'h8003, 16'h0000, 16'h0000, 16'h8002, 16'h0000, 16'h0000, 16'h000E \
}

// Layer 2, 8 inputs by 6 neurons.
`define FFNN_W2 { \
  16'h0002, 16'h8019, 16'h8003, 16'h8008, 16'h0010, 16'h0016, 16'h8002, 16'h8014, \
  16'h8006, 16'h0012, 16'h8005, 16'h8010, 16'h0014, 16'h8003, 16'h8013, 16'h800D, \
  16'h801E, 16'h000A, 16'h0009, 16'h8018, 16'h000D, 16'h8003, 16'h0004, 16'h0008, \
  16'h8018, 16'h0021, 16'h000C, 16'h8014, 16'h000B, 16'h8012, 16'h0012, 16'h000D, \
  16'h0012, 16'h000D, 16'h800A, 16'h8008, 16'h0014, 16'h800F, 16'h001B, 16'h801F, \
  16'h0023, 16'h0010, 16'h8016, 16'h001A, 16'h001A, 16'h0014, 16'h000B, 16'h001A  \
}

`define FFNN_B2 { \
  16'h0000, 16'h0008, 16'h000F, 16'h8008, 16'h8010, 16'h8001 \
}

// Output layer, 6 inputs by 3 classes.
`define FFNN_W3 { \
  16'h0000, 16'h800C, 16'h8009, 16'h000F, 16'h0019, 16'h8007, \
  16'h0004, 16'h0013, 16'h0017, 16'h8010, 16'h8019, 16'h801A, \
  16'h8006, 16'h8025, 16'h801D, 16'h8020, 16'h8016, 16'h0011  \
}

`define FFNN_B3 { \
  16'h801C, 16'h0004, 16'h0016 \
}

`endif
